// ==== logic/corePkg.sv ====
// Core widths, reset vector, opcode and funct fields, ALU and forward-select enums
package corePkg;

    // Datapath and register file sizing
    localparam int xlen    = 32;
    localparam int regAdrW = 5;

    // First fetch address after reset
    localparam logic [xlen-1:0] resetVector = 32'h8000_0000;

    // Major opcodes handled by the decoder
    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opReg   = 7'b0110011;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;

    // funct3 encodings
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Word width for LW and SW
    localparam logic [2:0] f3Word = 3'b010;

    // funct7 encodings
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;

    // ALU operations
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        // Operand B straight through, used by LUI
        aluPassB
    } aluOp_e;

    // Where an operand entering C comes from
    typedef enum logic [1:0] {
        noForward,
        fromMem,
        fromWrite
    } fwdSel_e;

endpackage

// ==== logic/stageIf.sv ====
// R-to-C and C-to-M pipeline bundles with their source and sink modports
`timescale 1ns/1ps

interface decodeToCompute;
    import corePkg::*;

    // Operand values as read in R
    logic [xlen-1:0]    operandA;
    logic [xlen-1:0]    operandB;
    logic [xlen-1:0]    storeData;

    // Register addresses, zero when the field is not a real source
    logic [regAdrW-1:0] rd;
    logic [regAdrW-1:0] rs1;
    logic [regAdrW-1:0] rs2;

    aluOp_e             aluOp;
    logic               useRs2;
    logic               regWrite;
    logic               memRead;
    logic               memWrite;

    modport source (
        output operandA, operandB, storeData, rd, rs1, rs2,
        output aluOp, useRs2, regWrite, memRead, memWrite
    );

    modport sink (
        input operandA, operandB, storeData, rd, rs1, rs2,
        input aluOp, useRs2, regWrite, memRead, memWrite
    );

endinterface

interface computeToRetire;
    import corePkg::*;

    // ALU result doubles as the memory address
    logic [xlen-1:0]    result;
    logic [xlen-1:0]    storeData;
    logic [regAdrW-1:0] rd;
    logic               regWrite;
    logic               memRead;
    logic               memWrite;

    modport source (output result, storeData, rd, regWrite, memRead, memWrite);

    modport sink (input result, storeData, rd, regWrite, memRead, memWrite);

endinterface

// ==== logic/fetchStage.sv ====
// Program counter and the I-to-R instruction register
`timescale 1ns/1ps

module fetchStage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,

    output logic [corePkg::xlen-1:0]  instrAdr,
    input  logic [corePkg::xlen-1:0]  instr,
    output logic [corePkg::xlen-1:0]  instrR
);
    import corePkg::*;

    logic [xlen-1:0] pc;

    // Straight-line fetch, no control flow in this core
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
        end else if (!stall) begin
            pc <= pc + xlen'(4);
        end
    end

    assign instrAdr = pc;

    // All-zero word decodes as a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            instrR <= '0;
        end else if (!stall) begin
            instrR <= instr;
        end
    end

endmodule

// ==== logic/decodeStage.sv ====
// Decoder, immediates, write-through register file and the R-to-C register
`timescale 1ns/1ps

module decodeStage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall,
    input  logic [corePkg::xlen-1:0]     instrR,

    output logic [corePkg::regAdrW-1:0]  rs1,
    output logic [corePkg::regAdrW-1:0]  rs2,

    input  logic                         wbEn,
    input  logic [corePkg::regAdrW-1:0]  wbAdr,
    input  logic [corePkg::xlen-1:0]     wbData,

    decodeToCompute.source               toCompute
);
    import corePkg::*;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [regAdrW-1:0] rd;
    logic [xlen-1:0]    immI, immS, immU, imm;
    logic [xlen-1:0]    rs1Data, rs2Data;
    aluOp_e             aluOp;
    logic               useRs1, useRs2, regWrite, memRead, memWrite;

    // x0 has no storage
    logic [xlen-1:0]    regs [1:31];

    assign opcode = instrR[6:0];
    assign funct3 = instrR[14:12];
    assign funct7 = instrR[31:25];
    assign rd     = instrR[11:7];

    assign immI = {{20{instrR[31]}}, instrR[31:20]};
    assign immS = {{20{instrR[31]}}, instrR[31:25], instrR[11:7]};
    assign immU = {instrR[31:12], 12'b0};

    // Anything unsupported stays a bubble
    always_comb begin
        aluOp    = aluAdd;
        imm      = immI;
        useRs1   = 1'b0;
        useRs2   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        case (opcode)
            opImm: begin
                useRs1   = 1'b1;
                regWrite = 1'b1;
                case (funct3)
                    f3AddSub: aluOp = aluAdd;
                    f3And:    aluOp = aluAnd;
                    f3Or:     aluOp = aluOr;
                    f3Xor:    aluOp = aluXor;
                    f3Slt:    aluOp = aluSlt;
                    default: begin
                        useRs1   = 1'b0;
                        regWrite = 1'b0;
                    end
                endcase
            end
            opReg: begin
                useRs1   = 1'b1;
                useRs2   = 1'b1;
                regWrite = 1'b1;
                case ({funct7, funct3})
                    {f7Base, f3AddSub}: aluOp = aluAdd;
                    {f7Alt, f3AddSub}:  aluOp = aluSub;
                    {f7Base, f3And}:    aluOp = aluAnd;
                    {f7Base, f3Or}:     aluOp = aluOr;
                    {f7Base, f3Xor}:    aluOp = aluXor;
                    {f7Base, f3Slt}:    aluOp = aluSlt;
                    {f7Base, f3Sll}:    aluOp = aluSll;
                    {f7Base, f3SrlSra}: aluOp = aluSrl;
                    default: begin
                        useRs1   = 1'b0;
                        useRs2   = 1'b0;
                        regWrite = 1'b0;
                    end
                endcase
            end
            opLui: begin
                aluOp    = aluPassB;
                imm      = immU;
                regWrite = 1'b1;
            end
            opLoad: begin
                if (funct3 == f3Word) begin
                    useRs1   = 1'b1;
                    regWrite = 1'b1;
                    memRead  = 1'b1;
                end
            end
            opStore: begin
                // Store data rides on rs2 while operand B carries the offset
                if (funct3 == f3Word) begin
                    imm      = immS;
                    useRs1   = 1'b1;
                    memWrite = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // Source fields that are not read become x0, so no false stall or forward
    assign rs1 = useRs1 ? instrR[19:15] : '0;
    assign rs2 = (useRs2 || memWrite) ? instrR[24:20] : '0;

    // Same-cycle write is visible to the read
    function automatic logic [xlen-1:0] readReg(logic [regAdrW-1:0] adr);
        logic [xlen-1:0] value;
        if (adr == '0) begin
            value = '0;
        end else if (wbEn && wbAdr == adr) begin
            value = wbData;
        end else begin
            value = regs[adr];
        end
        return value;
    endfunction

    always_comb begin
        rs1Data = readReg(rs1);
        rs2Data = readReg(rs2);
    end

    always_ff @(posedge clk) begin
        if (wbEn && wbAdr != '0) begin
            regs[wbAdr] <= wbData;
        end
    end

    // R-to-C control loads a bubble on reset or stall
    always_ff @(posedge clk) begin
        if (reset || stall) begin
            toCompute.regWrite <= 1'b0;
            toCompute.memRead  <= 1'b0;
            toCompute.memWrite <= 1'b0;
            toCompute.useRs2   <= 1'b0;
        end else begin
            toCompute.regWrite <= regWrite;
            toCompute.memRead  <= memRead;
            toCompute.memWrite <= memWrite;
            toCompute.useRs2   <= useRs2;
        end
    end

    // R-to-C payload
    always_ff @(posedge clk) begin
        toCompute.operandA  <= rs1Data;
        toCompute.operandB  <= useRs2 ? rs2Data : imm;
        toCompute.storeData <= rs2Data;
        toCompute.rd        <= rd;
        toCompute.rs1       <= rs1;
        toCompute.rs2       <= rs2;
        toCompute.aluOp     <= aluOp;
    end

endmodule

// ==== logic/computeStage.sv ====
// Forward muxes, ALU and the C-to-M register
`timescale 1ns/1ps

module computeStage (
    input  logic                     clk,
    input  logic                     reset,

    decodeToCompute.sink             fromDecode,

    input  corePkg::fwdSel_e         forwardA,
    input  corePkg::fwdSel_e         forwardB,
    input  logic [corePkg::xlen-1:0] wbData,

    computeToRetire.source           toRetire
);
    import corePkg::*;

    logic [xlen-1:0] srcA, srcB, storeDataC, aluResult;

    function automatic logic [xlen-1:0] pickOperand(
        fwdSel_e         sel,
        logic [xlen-1:0] regValue,
        logic [xlen-1:0] memValue,
        logic [xlen-1:0] writeValue
    );
        logic [xlen-1:0] value;
        case (sel)
            fromMem:   value = memValue;
            fromWrite: value = writeValue;
            default:   value = regValue;
        endcase
        return value;
    endfunction

    // x0 reads keep their zero no matter what the selects say
    always_comb begin
        srcA       = fromDecode.operandA;
        srcB       = fromDecode.operandB;
        storeDataC = fromDecode.storeData;
        if (fromDecode.rs1 != '0) begin
            srcA = pickOperand(forwardA, fromDecode.operandA, toRetire.result, wbData);
        end
        if (fromDecode.rs2 != '0) begin
            // Operand B may hold an immediate
            if (fromDecode.useRs2) begin
                srcB = pickOperand(forwardB, fromDecode.operandB, toRetire.result, wbData);
            end
            storeDataC = pickOperand(forwardB, fromDecode.storeData, toRetire.result, wbData);
        end
    end

    always_comb begin
        case (fromDecode.aluOp)
            aluAdd:   aluResult = srcA + srcB;
            aluSub:   aluResult = srcA - srcB;
            aluAnd:   aluResult = srcA & srcB;
            aluOr:    aluResult = srcA | srcB;
            aluXor:   aluResult = srcA ^ srcB;
            aluSlt:   aluResult = xlen'($signed(srcA) < $signed(srcB));
            aluSll:   aluResult = srcA << srcB[4:0];
            aluSrl:   aluResult = srcA >> srcB[4:0];
            aluPassB: aluResult = srcB;
            default:  aluResult = '0;
        endcase
    end

    // C-to-M control
    always_ff @(posedge clk) begin
        if (reset) begin
            toRetire.regWrite <= 1'b0;
            toRetire.memRead  <= 1'b0;
            toRetire.memWrite <= 1'b0;
        end else begin
            toRetire.regWrite <= fromDecode.regWrite;
            toRetire.memRead  <= fromDecode.memRead;
            toRetire.memWrite <= fromDecode.memWrite;
        end
    end

    // C-to-M payload
    always_ff @(posedge clk) begin
        toRetire.result    <= aluResult;
        toRetire.storeData <= storeDataC;
        toRetire.rd        <= fromDecode.rd;
    end

endmodule

// ==== logic/retireStage.sv ====
// M-to-W register and writeback result select
`timescale 1ns/1ps

module retireStage (
    input  logic                         clk,
    input  logic                         reset,

    computeToRetire.sink                 fromCompute,
    input  logic [corePkg::xlen-1:0]     memReadData,

    output logic                         wbEn,
    output logic [corePkg::regAdrW-1:0]  wbAdr,
    output logic [corePkg::xlen-1:0]     wbData
);
    import corePkg::*;

    logic [xlen-1:0]    resultW, readDataW;
    logic [regAdrW-1:0] rdW;
    logic               regWriteW, memReadW;

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteW <= 1'b0;
            memReadW  <= 1'b0;
        end else begin
            regWriteW <= fromCompute.regWrite;
            memReadW  <= fromCompute.memRead;
        end
    end

    // Read data is captured in the same cycle the address is out
    always_ff @(posedge clk) begin
        resultW   <= fromCompute.result;
        readDataW <= memReadData;
        rdW       <= fromCompute.rd;
    end

    assign wbEn   = regWriteW;
    assign wbAdr  = rdW;
    assign wbData = memReadW ? readDataW : resultW;

endmodule

// ==== logic/hazardUnit.sv ====
// Forward selects for the C-stage operands and the load-use stall
`timescale 1ns/1ps

module hazardUnit (
    input  logic                         clk,
    input  logic                         reset,

    input  logic [corePkg::regAdrW-1:0]  rs1R,
    input  logic [corePkg::regAdrW-1:0]  rs2R,
    input  logic [corePkg::regAdrW-1:0]  rdC,
    input  logic                         regWriteC,
    input  logic                         memReadC,
    input  logic [corePkg::regAdrW-1:0]  rdM,
    input  logic                         regWriteM,
    input  logic                         wbEn,
    input  logic [corePkg::regAdrW-1:0]  wbAdr,

    output logic                         stall,
    output corePkg::fwdSel_e             forwardA,
    output corePkg::fwdSel_e             forwardB
);
    import corePkg::*;

    // Sources of the instruction now in C
    logic [regAdrW-1:0] rs1C, rs2C;

    function automatic fwdSel_e forwardFor(logic [regAdrW-1:0] rs);
        fwdSel_e sel;
        if (regWriteM && rdM != '0 && rdM == rs) begin
            sel = fromMem;
        end else if (wbEn && wbAdr != '0 && wbAdr == rs) begin
            sel = fromWrite;
        end else begin
            sel = noForward;
        end
        return sel;
    endfunction

    // Cleared along with the bubble that enters C
    always_ff @(posedge clk) begin
        if (reset || stall) begin
            rs1C <= '0;
            rs2C <= '0;
        end else begin
            rs1C <= rs1R;
            rs2C <= rs2R;
        end
    end

    always_comb begin
        forwardA = forwardFor(rs1C);
        forwardB = forwardFor(rs2C);
    end

    // Load in C feeding the instruction in R
    assign stall = memReadC && regWriteC && rdC != '0 && (rdC == rs1R || rdC == rs2R);

endmodule

// ==== logic/coreTop.sv ====
// Five-stage RV32I core top level with external instruction and data ports
`timescale 1ns/1ps

module coreTop (
    input  logic                      clk,
    input  logic                      reset,

    // Instruction port
    output logic [corePkg::xlen-1:0]  instrAdr,
    input  logic [corePkg::xlen-1:0]  instr,

    // Data memory port, combinational read
    output logic                      memEn,
    output logic                      memWriteEn,
    output logic [corePkg::xlen-1:0]  memAdr,
    output logic [corePkg::xlen-1:0]  memWriteData,
    input  logic [corePkg::xlen-1:0]  memReadData
);
    import corePkg::*;

    logic [xlen-1:0]    instrR;
    logic [regAdrW-1:0] rs1R, rs2R;
    logic               stall;
    fwdSel_e            forwardA, forwardB;

    logic               wbEn;
    logic [regAdrW-1:0] wbAdr;
    logic [xlen-1:0]    wbData;

    decodeToCompute dToC ();
    computeToRetire cToR ();

    fetchStage fetch_i (
        .clk, .reset, .stall, .instrAdr, .instr, .instrR
    );

    decodeStage decode_i (
        .clk, .reset, .stall, .instrR,
        .rs1(rs1R), .rs2(rs2R),
        .wbEn, .wbAdr, .wbData,
        .toCompute(dToC.source)
    );

    computeStage compute_i (
        .clk, .reset,
        .fromDecode(dToC.sink),
        .forwardA, .forwardB, .wbData,
        .toRetire(cToR.source)
    );

    retireStage retire_i (
        .clk, .reset,
        .fromCompute(cToR.sink),
        .memReadData,
        .wbEn, .wbAdr, .wbData
    );

    hazardUnit hazard_i (
        .clk, .reset, .rs1R, .rs2R,
        .rdC(dToC.rd), .regWriteC(dToC.regWrite), .memReadC(dToC.memRead),
        .rdM(cToR.rd), .regWriteM(cToR.regWrite),
        .wbEn, .wbAdr,
        .stall, .forwardA, .forwardB
    );

    // M stage drives the data port
    assign memEn        = cToR.memRead | cToR.memWrite;
    assign memWriteEn   = cToR.memWrite;
    assign memAdr       = cToR.result;
    assign memWriteData = cToR.storeData;

endmodule

// ==== dv/coreHazard_properties.sv ====
// Concurrent checks on the load-use stall, the data port enables and the state after reset
`timescale 1ns/1ps

module coreHazard_properties (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic memEn,
    input logic memWriteEn,
    input logic wbEn
);

    // A load-use stall lasts exactly one cycle
    stallOneCycle: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
        else $error("stall stayed high for two cycles in a row");

    // A write always comes with the memory enable
    writeNeedsEnable: assert property (@(posedge clk) disable iff (reset) memWriteEn |-> memEn)
        else $error("memWriteEn high while memEn is low");

    // Pipeline leaves reset holding only bubbles
    quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> !memEn && !wbEn)
        else $error("memory or writeback enable high in the first cycle after reset");

endmodule

// The stall comes out of the hazard unit, the enables out of the M and W stages
bind coreTop coreHazard_properties props_i (
    .clk, .reset, .stall, .memEn, .memWriteEn, .wbEn
);

// ==== dv/coreTb.sv ====
// Testbench for the pipelined core with memory models, program table and expected-store table
`timescale 1ns/1ps

module coreTb;
    import corePkg::*;

    localparam int clkPeriod   = 10;
    localparam int resetCycles = 10;
    localparam int progLen     = 43;
    localparam int progDepth   = 64;
    localparam int numStores   = 18;

    logic            clk;
    logic            reset;
    logic [xlen-1:0] instrAdr;
    logic [xlen-1:0] instr;
    logic            memEn;
    logic            memWriteEn;
    logic [xlen-1:0] memAdr;
    logic [xlen-1:0] memWriteData;
    logic [xlen-1:0] memReadData;

    logic [xlen-1:0] progMem [0:progDepth-1];
    logic [xlen-1:0] dataMem [0:255];
    // Address in the upper half, data in the lower half
    logic [63:0]     expected [0:numStores-1];
    logic [xlen-1:0] instrOffset;
    int              storeIdx = 0;
    int              errors = 0;

    coreTop dut_i (
        .clk, .reset, .instrAdr, .instr,
        .memEn, .memWriteEn, .memAdr, .memWriteData, .memReadData
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // RV32I encoders
    function automatic logic [31:0] regOp(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                          int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] immOp(logic [2:0] f3, int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] loadWord(int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic logic [31:0] storeWord(int rs2, int rs1, int imm);
        logic [11:0] s;
        s = 12'(imm);
        return {s[11:5], 5'(rs2), 5'(rs1), 3'b010, s[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] loadUpper(int rd, logic [19:0] imm);
        return {imm, 5'(rd), 7'b0110111};
    endfunction

    task automatic checkValue(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic reportAndFinish();
        $display("closing: %0d errors, %0d of %0d stores seen", errors, storeIdx, numStores);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // Instruction memory reads zero past the table
    assign instrOffset = instrAdr - resetVector;
    assign instr = (instrOffset < 32'(progDepth * 4)) ? progMem[instrOffset[7:2]] : '0;

    // Data memory with combinational read
    assign memReadData = dataMem[memAdr[9:2]];

    initial begin
        for (int i = 0; i < progDepth; i++) begin
            progMem[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dataMem[i] = 32'hD47A_0000 | 32'(i << 2);
        end
        // Load sources at 0x1F0 and 0x1F4
        dataMem[8'h7C] = 32'h1234_5678;
        dataMem[8'h7D] = 32'h0000_0010;

        // Base register, immediate ops and LUI
        progMem[0]  = immOp(3'b000, 10, 0, 'h100);
        progMem[1]  = immOp(3'b000, 1, 0, 5);
        progMem[2]  = immOp(3'b000, 2, 0, -3);
        progMem[3]  = immOp(3'b111, 3, 2, 'h0F0);
        progMem[4]  = immOp(3'b110, 4, 1, 'h700);
        progMem[5]  = immOp(3'b100, 5, 2, 'h0FF);
        progMem[6]  = immOp(3'b010, 6, 2, 1);
        progMem[7]  = loadUpper(7, 20'hABCDE);
        progMem[8]  = storeWord(1, 10, 0);
        progMem[9]  = storeWord(2, 10, 4);
        progMem[10] = storeWord(3, 10, 8);
        progMem[11] = storeWord(4, 10, 12);
        progMem[12] = storeWord(5, 10, 16);
        progMem[13] = storeWord(6, 10, 20);
        progMem[14] = storeWord(7, 10, 24);
        // Back-to-back dependent chain
        progMem[15] = regOp(7'b0000000, 3'b000, 11, 1, 2);
        progMem[16] = regOp(7'b0100000, 3'b000, 12, 11, 1);
        progMem[17] = regOp(7'b0000000, 3'b001, 13, 1, 11);
        progMem[18] = regOp(7'b0000000, 3'b100, 14, 12, 13);
        progMem[19] = regOp(7'b0000000, 3'b101, 15, 14, 11);
        progMem[20] = regOp(7'b0000000, 3'b110, 16, 15, 13);
        progMem[21] = regOp(7'b0000000, 3'b111, 17, 16, 14);
        progMem[22] = regOp(7'b0000000, 3'b010, 18, 12, 17);
        progMem[23] = storeWord(18, 10, 28);
        progMem[24] = storeWord(17, 10, 32);
        progMem[25] = storeWord(16, 10, 36);
        progMem[26] = storeWord(15, 10, 40);
        progMem[27] = storeWord(14, 10, 44);
        progMem[28] = storeWord(13, 10, 48);
        // Load-use pairs
        progMem[29] = loadWord(19, 10, 'h0F0);
        progMem[30] = immOp(3'b000, 20, 19, 1);
        progMem[31] = loadWord(21, 10, 'h0F4);
        progMem[32] = regOp(7'b0000000, 3'b000, 22, 21, 20);
        progMem[33] = storeWord(22, 10, 52);
        progMem[34] = loadWord(23, 10, 'h0F0);
        progMem[35] = storeWord(23, 10, 56);
        // Forwarded base with a negative offset
        progMem[36] = immOp(3'b000, 24, 10, 'h80);
        progMem[37] = storeWord(20, 24, -4);
        // Writes to x0
        progMem[38] = immOp(3'b000, 0, 0, 'h55);
        progMem[39] = regOp(7'b0000000, 3'b000, 0, 1, 1);
        progMem[40] = storeWord(0, 10, 60);
        progMem[41] = immOp(3'b000, 25, 0, 7);
        progMem[42] = storeWord(25, 10, 64);

        expected[0]  = {32'h0000_0100, 32'h0000_0005};
        expected[1]  = {32'h0000_0104, 32'hFFFF_FFFD};
        expected[2]  = {32'h0000_0108, 32'h0000_00F0};
        expected[3]  = {32'h0000_010C, 32'h0000_0705};
        expected[4]  = {32'h0000_0110, 32'hFFFF_FF02};
        expected[5]  = {32'h0000_0114, 32'h0000_0001};
        expected[6]  = {32'h0000_0118, 32'hABCD_E000};
        expected[7]  = {32'h0000_011C, 32'h0000_0001};
        expected[8]  = {32'h0000_0120, 32'h3FFF_FFE8};
        expected[9]  = {32'h0000_0124, 32'h3FFF_FFFE};
        expected[10] = {32'h0000_0128, 32'h3FFF_FFFA};
        expected[11] = {32'h0000_012C, 32'hFFFF_FFE9};
        expected[12] = {32'h0000_0130, 32'h0000_0014};
        expected[13] = {32'h0000_0134, 32'h1234_5689};
        expected[14] = {32'h0000_0138, 32'h1234_5678};
        expected[15] = {32'h0000_017C, 32'h1234_5679};
        expected[16] = {32'h0000_013C, 32'h0000_0000};
        expected[17] = {32'h0000_0140, 32'h0000_0007};
    end

    // Walk the expected stores as they appear on the port
    always @(posedge clk) begin
        if (!reset && memEn && memWriteEn) begin
            dataMem[memAdr[9:2]] <= memWriteData;
            if (storeIdx < numStores) begin
                checkValue($sformatf("store %0d address", storeIdx),
                           expected[storeIdx][63:32], memAdr);
                checkValue($sformatf("store %0d data", storeIdx),
                           expected[storeIdx][31:0], memWriteData);
            end else begin
                errors++;
                $display("unexpected store to %h after the program's last store", memAdr);
            end
            storeIdx++;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) begin
            @(negedge clk);
            checkValue("reset instrAdr", resetVector, instrAdr);
            checkValue("reset memEn", '0, 32'(memEn));
            checkValue("reset memWriteEn", '0, 32'(memWriteEn));
        end
        reset = 1'b0;
        checkValue("first fetch instrAdr", resetVector, instrAdr);
        @(negedge clk);
        checkValue("after reset memEn", '0, 32'(memEn));
        checkValue("after reset memWriteEn", '0, 32'(memWriteEn));
        wait (storeIdx >= numStores);
        repeat (5) @(negedge clk);
        reportAndFinish();
    end

    // Watchdog
    initial begin
        #((progLen + 30) * clkPeriod + resetCycles * clkPeriod);
        $display("timeout: only %0d of %0d expected stores were seen", storeIdx, numStores);
        errors++;
        reportAndFinish();
    end

endmodule

// ==== src.f ====
logic/corePkg.sv
logic/stageIf.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/computeStage.sv
logic/retireStage.sv
logic/hazardUnit.sv
logic/coreTop.sv
dv/coreHazard_properties.sv
dv/coreTb.sv

// ==== Bender.yml ====
package:
  name: rv32i_pipe_core

sources:
  - logic/corePkg.sv
  - logic/stageIf.sv
  - logic/fetchStage.sv
  - logic/decodeStage.sv
  - logic/computeStage.sv
  - logic/retireStage.sv
  - logic/hazardUnit.sv
  - logic/coreTop.sv
  - target: test
    files:
      - dv/coreHazard_properties.sv
      - dv/coreTb.sv
